// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 64;
    localparam int reg_count = 32;
    localparam logic [xlen-1:0] reset_pc = '0;

    // control unit states
    typedef enum logic [3:0] {
        idle,
        fetch,
        fetch_wait,
        decode,
        reg_reg,
        reg_imm,
        lui_st,
        auipc_st,
        jal_st,
        branch,
        jalr_st,
        load,
        load_wait,
        store,
        store_wait,
        halt
    } ctrl_state_t;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_t;

    // alu operation, same encoding as funct3
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu  = 2'b00,
        wb_load = 2'b01,
        wb_pc4  = 2'b10
    } wb_sel_t;

endpackage

// ==== rtl/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_t         op,
    input  logic                    sub,
    input  logic                    arithmetic,
    output logic [rv_pkg::xlen-1:0] y,
    output logic                    zero,
    output logic                    negative,
    output logic                    carry_out,
    output logic                    overflow
);
    import rv_pkg::*;

    logic            do_sub;
    logic [xlen-1:0] b_eff;
    logic [xlen:0]   sum;
    logic [5:0]      shamt;

    // compares always go through the subtractor
    assign do_sub = sub || op == alu_slt || op == alu_sltu;
    assign b_eff  = do_sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {{xlen{1'b0}}, do_sub};
    assign shamt  = b[5:0];

    assign carry_out = sum[xlen];
    assign negative  = sum[xlen-1];
    assign zero      = (sum[xlen-1:0] == '0);
    assign overflow  = (a[xlen-1] == b_eff[xlen-1]) && (sum[xlen-1] != a[xlen-1]);

    always_comb
    begin
        case (op)
            alu_sll:  y = a << shamt;
            alu_slt:  y = {{(xlen-1){1'b0}}, negative ^ overflow};
            alu_sltu: y = {{(xlen-1){1'b0}}, ~carry_out};
            alu_xor:  y = a ^ b;
            alu_srl:
            begin
                if (arithmetic)
                    y = $unsigned($signed(a) >>> shamt);
                else
                    y = a >> shamt;
            end
            alu_or:   y = a | b;
            alu_and:  y = a & b;
            default:  y = sum[xlen-1:0];
        endcase
    end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic                    mem_busy,
    input  logic                    reset,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    input  logic [4:0]              rd_addr,
    input  logic [rv_pkg::xlen-1:0] rd_data,
    input  logic                    wr_en,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge mem_busy or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
        end
        else if (wr_en && rd_addr != 5'd0)
        begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== rtl/datapath.sv ====
`timescale 1ns/1ns

module datapath (
    input  logic                    mem_busy,
    input  logic                    reset,
    input  logic [rv_pkg::xlen-1:0] mem_rdata,
    input  logic                    alua_src,
    input  logic                    alub_src,
    input  logic                    aluy_src,
    input  rv_pkg::alu_op_t         alu_op,
    input  logic                    sub,
    input  logic                    arithmetic,
    input  logic                    alupc_src,
    input  logic                    pc_src,
    input  logic                    pc_en,
    input  rv_pkg::wb_sel_t         wb_sel,
    input  logic                    wr_reg_en,
    input  logic                    ir_en,
    input  logic                    mem_addr_src,
    input  logic [7:0]              byte_mask,
    output logic [rv_pkg::xlen-1:0] mem_addr,
    output logic [rv_pkg::xlen-1:0] mem_wdata,
    output logic [7:0]              mem_byte_en,
    output rv_pkg::opcode_t         opcode,
    output logic [2:0]              funct3,
    output logic [6:0]              funct7,
    output logic                    zero,
    output logic                    negative,
    output logic                    carry_out,
    output logic                    overflow
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic [31:0]     ir;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] rd_data;
    logic [xlen-1:0] lane_data;
    logic [xlen-1:0] load_data;
    logic [5:0]      lane_shift;

    assign opcode = opcode_t'(ir[6:0]);
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    always_ff @(posedge mem_busy or posedge reset)
    begin
        if (reset)
        begin
            pc <= reset_pc;
        end
        else if (pc_en)
        begin
            pc <= pc_src ? pc_target : pc_plus4;
        end
    end

    // instruction sits in the upper half of the bus word when pc[2] is set
    always_ff @(posedge mem_busy)
    begin
        if (ir_en)
            ir <= pc[2] ? mem_rdata[63:32] : mem_rdata[31:0];
    end

    always_comb
    begin
        case (opcode)
            opc_op_imm, opc_jalr, opc_load:
                imm = {{52{ir[31]}}, ir[31:20]};
            opc_store:
                imm = {{52{ir[31]}}, ir[31:25], ir[11:7]};
            opc_branch:
                imm = {{52{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            opc_lui, opc_auipc:
                imm = {{32{ir[31]}}, ir[31:12], 12'h000};
            opc_jal:
                imm = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    register_file u_regs (
        .mem_busy (mem_busy),
        .reset    (reset),
        .rs1_addr (ir[19:15]),
        .rs2_addr (ir[24:20]),
        .rd_addr  (ir[11:7]),
        .rd_data  (rd_data),
        .wr_en    (wr_reg_en),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_a = alua_src ? pc : rs1_data;
    assign alu_b = alub_src ? imm : rs2_data;

    alu u_alu (
        .a          (alu_a),
        .b          (alu_b),
        .op         (alu_op),
        .sub        (sub),
        .arithmetic (arithmetic),
        .y          (alu_y),
        .zero       (zero),
        .negative   (negative),
        .carry_out  (carry_out),
        .overflow   (overflow)
    );

    assign pc_plus4  = pc + 64'd4;
    // jalr target has bit 0 cleared
    assign pc_target = alupc_src ? {alu_y[xlen-1:1], 1'b0} : pc + imm;

    assign mem_addr    = mem_addr_src ? alu_y : pc;
    assign lane_shift  = {mem_addr[2:0], 3'b000};
    assign mem_byte_en = byte_mask << mem_addr[2:0];
    assign mem_wdata   = rs2_data << lane_shift;

    assign lane_data = mem_rdata >> lane_shift;

    always_comb
    begin
        case (funct3)
            3'b000:  load_data = {{56{lane_data[7]}}, lane_data[7:0]};
            3'b001:  load_data = {{48{lane_data[15]}}, lane_data[15:0]};
            3'b010:  load_data = {{32{lane_data[31]}}, lane_data[31:0]};
            3'b100:  load_data = {56'd0, lane_data[7:0]};
            3'b101:  load_data = {48'd0, lane_data[15:0]};
            3'b110:  load_data = {32'd0, lane_data[31:0]};
            default: load_data = lane_data;
        endcase
    end

    always_comb
    begin
        case (wb_sel)
            wb_load: rd_data = load_data;
            wb_pc4:  rd_data = pc_plus4;
            default: rd_data = aluy_src ? imm : alu_y;
        endcase
    end

endmodule

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ns

module control_unit (
    input  logic             mem_busy,
    input  logic             reset,
    input  logic             mem_ack,
    input  rv_pkg::opcode_t  opcode,
    input  logic [2:0]       funct3,
    input  logic [6:0]       funct7,
    input  logic             zero,
    input  logic             negative,
    input  logic             carry_out,
    input  logic             overflow,
    output logic             mem_rd_en,
    output logic             mem_wr_en,
    output logic [7:0]       mem_byte_en,
    output logic             alua_src,
    output logic             alub_src,
    output logic             aluy_src,
    output rv_pkg::alu_op_t  alu_op,
    output logic             sub,
    output logic             arithmetic,
    output logic             alupc_src,
    output logic             pc_src,
    output logic             pc_en,
    output rv_pkg::wb_sel_t  wb_sel,
    output logic             wr_reg_en,
    output logic             ir_en,
    output logic             mem_addr_src,
    output logic             halted
);
    import rv_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        known_op;
    logic        take_branch;
    logic [7:0]  size_mask;

    always_ff @(posedge mem_busy or posedge reset)
    begin
        if (reset)
        begin
            state <= idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    assign known_op = opcode inside {opc_op, opc_op_imm, opc_lui, opc_auipc, opc_jal,
                                     opc_jalr, opc_branch, opc_load, opc_store};

    // branch decision from the flags of rs1 - rs2
    always_comb
    begin
        if (funct3[1])
            take_branch = carry_out ~^ funct3[0];
        else if (funct3[2])
            take_branch = (negative ^ overflow) ^ funct3[0];
        else
            take_branch = zero ^ funct3[0];
    end

    always_comb
    begin
        case (funct3[1:0])
            2'b00:   size_mask = 8'h01;
            2'b01:   size_mask = 8'h03;
            2'b10:   size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    assign halted = (state == halt);

    always_comb
    begin
        next_state   = state;
        mem_rd_en    = 1'b0;
        mem_wr_en    = 1'b0;
        mem_byte_en  = 8'h00;
        alua_src     = 1'b0;
        alub_src     = 1'b0;
        aluy_src     = 1'b0;
        alu_op       = alu_add;
        sub          = 1'b0;
        arithmetic   = 1'b0;
        alupc_src    = 1'b0;
        pc_src       = 1'b0;
        pc_en        = 1'b0;
        wb_sel       = wb_alu;
        wr_reg_en    = 1'b0;
        ir_en        = 1'b0;
        mem_addr_src = 1'b0;

        case (state)
            idle:
            begin
                next_state = fetch;
            end

            // ack may arrive in the first request cycle already
            fetch, fetch_wait:
            begin
                mem_rd_en   = 1'b1;
                mem_byte_en = 8'h0f;
                ir_en       = mem_ack;
                next_state  = mem_ack ? decode : fetch_wait;
            end

            decode:
            begin
                if (opcode[1:0] != 2'b11 || !known_op)
                    next_state = halt;
                else if (opcode[4])
                begin
                    if (opcode[5])
                        next_state = opcode[2] ? lui_st : reg_reg;
                    else
                        next_state = opcode[2] ? auipc_st : reg_imm;
                end
                else if (opcode[6])
                begin
                    if (opcode[3])
                        next_state = jal_st;
                    else
                        next_state = opcode[2] ? jalr_st : branch;
                end
                else
                begin
                    next_state = opcode[5] ? store : load;
                end
            end

            reg_reg:
            begin
                alu_op     = alu_op_t'(funct3);
                sub        = funct7[5];
                arithmetic = funct7[5];
                pc_en      = 1'b1;
                wr_reg_en  = 1'b1;
                next_state = fetch;
            end

            reg_imm:
            begin
                alub_src   = 1'b1;
                alu_op     = alu_op_t'(funct3);
                // only srai carries the arithmetic bit in its immediate
                arithmetic = funct7[5] & (funct3 == 3'b101);
                pc_en      = 1'b1;
                wr_reg_en  = 1'b1;
                next_state = fetch;
            end

            lui_st:
            begin
                alub_src   = 1'b1;
                aluy_src   = 1'b1;
                pc_en      = 1'b1;
                wr_reg_en  = 1'b1;
                next_state = fetch;
            end

            auipc_st:
            begin
                alua_src   = 1'b1;
                alub_src   = 1'b1;
                pc_en      = 1'b1;
                wr_reg_en  = 1'b1;
                next_state = fetch;
            end

            jal_st:
            begin
                pc_src     = 1'b1;
                pc_en      = 1'b1;
                wb_sel     = wb_pc4;
                wr_reg_en  = 1'b1;
                next_state = fetch;
            end

            branch:
            begin
                sub        = 1'b1;
                pc_src     = take_branch;
                pc_en      = 1'b1;
                next_state = fetch;
            end

            jalr_st:
            begin
                alub_src   = 1'b1;
                alupc_src  = 1'b1;
                pc_src     = 1'b1;
                pc_en      = 1'b1;
                wb_sel     = wb_pc4;
                wr_reg_en  = 1'b1;
                next_state = fetch;
            end

            load, load_wait:
            begin
                alub_src     = 1'b1;
                mem_addr_src = 1'b1;
                mem_rd_en    = 1'b1;
                mem_byte_en  = size_mask;
                wb_sel       = wb_load;
                pc_en        = mem_ack;
                wr_reg_en    = mem_ack;
                next_state   = mem_ack ? fetch : load_wait;
            end

            store, store_wait:
            begin
                alub_src     = 1'b1;
                mem_addr_src = 1'b1;
                mem_wr_en    = 1'b1;
                mem_byte_en  = size_mask;
                pc_en        = mem_ack;
                next_state   = mem_ack ? fetch : store_wait;
            end

            default:
            begin
                next_state = halt;
            end
        endcase
    end

endmodule

// ==== rtl/rv64i_core.sv ====
`timescale 1ns/1ns

module rv64i_core (
    input  logic                    mem_busy,
    input  logic                    reset,
    input  logic [rv_pkg::xlen-1:0] mem_rdata,
    input  logic                    mem_ack,
    output logic [rv_pkg::xlen-1:0] mem_addr,
    output logic [rv_pkg::xlen-1:0] mem_wdata,
    output logic [7:0]              mem_byte_en,
    output logic                    mem_rd_en,
    output logic                    mem_wr_en,
    output logic                    halted
);
    import rv_pkg::*;

    logic       alua_src;
    logic       alub_src;
    logic       aluy_src;
    alu_op_t    alu_op;
    logic       sub;
    logic       arithmetic;
    logic       alupc_src;
    logic       pc_src;
    logic       pc_en;
    wb_sel_t    wb_sel;
    logic       wr_reg_en;
    logic       ir_en;
    logic       mem_addr_src;
    logic [7:0] byte_mask;
    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       zero;
    logic       negative;
    logic       carry_out;
    logic       overflow;

    // size mask from control, placed on the byte lanes by the datapath
    control_unit u_ctrl (
        .mem_busy     (mem_busy),
        .reset        (reset),
        .mem_ack      (mem_ack),
        .opcode       (opcode),
        .funct3       (funct3),
        .funct7       (funct7),
        .zero         (zero),
        .negative     (negative),
        .carry_out    (carry_out),
        .overflow     (overflow),
        .mem_rd_en    (mem_rd_en),
        .mem_wr_en    (mem_wr_en),
        .mem_byte_en  (byte_mask),
        .alua_src     (alua_src),
        .alub_src     (alub_src),
        .aluy_src     (aluy_src),
        .alu_op       (alu_op),
        .sub          (sub),
        .arithmetic   (arithmetic),
        .alupc_src    (alupc_src),
        .pc_src       (pc_src),
        .pc_en        (pc_en),
        .wb_sel       (wb_sel),
        .wr_reg_en    (wr_reg_en),
        .ir_en        (ir_en),
        .mem_addr_src (mem_addr_src),
        .halted       (halted)
    );

    datapath u_dp (
        .mem_busy     (mem_busy),
        .reset        (reset),
        .mem_rdata    (mem_rdata),
        .alua_src     (alua_src),
        .alub_src     (alub_src),
        .aluy_src     (aluy_src),
        .alu_op       (alu_op),
        .sub          (sub),
        .arithmetic   (arithmetic),
        .alupc_src    (alupc_src),
        .pc_src       (pc_src),
        .pc_en        (pc_en),
        .wb_sel       (wb_sel),
        .wr_reg_en    (wr_reg_en),
        .ir_en        (ir_en),
        .mem_addr_src (mem_addr_src),
        .byte_mask    (byte_mask),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .opcode       (opcode),
        .funct3       (funct3),
        .funct7       (funct7),
        .zero         (zero),
        .negative     (negative),
        .carry_out    (carry_out),
        .overflow     (overflow)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for 8 rising edges
    initial
    begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== tb/rv64i_tb.sv ====
`timescale 1ns/1ns

module rv64i_tb;

    logic        mem_busy;
    logic        reset;
    logic [63:0] mem_rdata;
    logic        mem_ack;
    logic [63:0] mem_addr;
    logic [63:0] mem_wdata;
    logic [7:0]  mem_byte_en;
    logic        mem_rd_en;
    logic        mem_wr_en;
    logic        halted;

    logic [63:0] data_in [0:255];
    logic [63:0] mem [0:1023];
    logic [31:0] lfsr;
    int          word_count;
    int          exp_count;
    int          rec_base;
    int          store_idx;
    int          cycle_count;
    int          timeout_limit;
    int          wait_left;
    int          quiet_cycles;
    logic        busy;
    logic        first_done;
    logic        seen_halt;
    logic        ack_seen;
    logic [63:0] req_addr;
    logic [63:0] req_wdata;
    logic [7:0]  req_be;
    logic        req_wr;

    tb_clock_gen u_clk (
        .clk   (mem_busy),
        .reset (reset)
    );

    rv64i_core u_dut (
        .mem_busy    (mem_busy),
        .reset       (reset),
        .mem_rdata   (mem_rdata),
        .mem_ack     (mem_ack),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .mem_rd_en   (mem_rd_en),
        .mem_wr_en   (mem_wr_en),
        .halted      (halted)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // galois form, taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h80200003;
        return n;
    endfunction

    task automatic random_delay(output int d);
        logic [2:0] bits;
        bits = 3'd0;
        for (int i = 0; i < 3; i++)
        begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[1:0], lfsr[0]};
        end
        d = int'(bits);
    endtask

    // current request equals the one that was accepted
    function automatic logic request_held();
        return mem_addr == req_addr && mem_byte_en == req_be
               && mem_wr_en == req_wr && mem_rd_en == !req_wr
               && (!req_wr || mem_wdata == req_wdata);
    endfunction

    task automatic check_store();
        int base;
        base = rec_base + 3 * store_idx;
        assert (store_idx < exp_count)
        else fail_run($sformatf("[FAIL] %0t ns: extra store to %h", $time, req_addr));
        assert (req_addr == data_in[base] && req_be == data_in[base+1][7:0]
                && req_wdata == data_in[base+2])
        else fail_run($sformatf("[FAIL] %0t ns: store %0d got %h/%h/%h, expected %h/%h/%h",
                                $time, store_idx, req_addr, req_be, req_wdata,
                                data_in[base], data_in[base+1][7:0], data_in[base+2]));
        store_idx++;
    endtask

    task automatic finish_request();
        mem_ack <= 1'b1;
        busy = 1'b0;
        if (req_wr)
        begin
            check_store();
            for (int b = 0; b < 8; b++)
                if (req_be[b])
                    mem[req_addr[12:3]][8*b +: 8] = req_wdata[8*b +: 8];
        end
        else
        begin
            mem_rdata <= mem[req_addr[12:3]];
        end
    endtask

    initial
    begin
        mem_ack      = 1'b0;
        mem_rdata    = 64'd0;
        lfsr         = 32'h03ada9b9;
        busy         = 1'b0;
        first_done   = 1'b0;
        seen_halt    = 1'b0;
        ack_seen     = 1'b0;
        store_idx    = 0;
        cycle_count  = 0;
        quiet_cycles = 0;
        $readmemh("tb/program_input.txt", data_in);
        word_count = int'(data_in[0]);
        for (int i = 0; i < 1024; i++)
            mem[i] = {32'hc0de0000 ^ i, ~i};
        for (int i = 0; i < word_count; i++)
            mem[i/2][32*(i%2) +: 32] = data_in[1+i][31:0];
        exp_count     = int'(data_in[word_count+1]);
        rec_base      = word_count + 2;
        timeout_limit = word_count * 8 * (7 + 4);
    end

    always @(posedge mem_busy)
    begin
        if (reset)
        begin
            assert (!mem_rd_en && !mem_wr_en && !halted)
            else fail_run($sformatf("[FAIL] %0t ns: outputs active in reset", $time));
        end
        else
        begin
            cycle_count++;
            if (cycle_count > timeout_limit)
                fail_run($sformatf("the core did not halt within %0d cycles", timeout_limit));
            assert (!(mem_rd_en && mem_wr_en))
            else fail_run($sformatf("[FAIL] %0t ns: read and write together", $time));

            if (ack_seen)
            begin
                // a new request may follow, the acked one must be gone
                assert (!(mem_rd_en || mem_wr_en) || mem_addr != req_addr
                        || mem_wr_en != req_wr)
                else fail_run($sformatf("[FAIL] %0t ns: request held after ack", $time));
                ack_seen = 1'b0;
            end

            if (seen_halt)
            begin
                assert (halted && !mem_rd_en && !mem_wr_en)
                else fail_run($sformatf("[FAIL] %0t ns: activity after halt", $time));
                quiet_cycles++;
                if (quiet_cycles == 20)
                begin
                    if (store_idx == exp_count)
                    begin
                        $display(">>> PASS");
                        $finish;
                    end
                    else
                        fail_run($sformatf("[FAIL] %0t ns: %0d stores, expected %0d",
                                           $time, store_idx, exp_count));
                end
            end
            else if (halted)
            begin
                seen_halt = 1'b1;
            end
            else if (mem_ack)
            begin
                // request still held in the ack cycle
                assert (request_held())
                else fail_run($sformatf("[FAIL] %0t ns: request changed in ack cycle", $time));
                mem_ack <= 1'b0;
                ack_seen = 1'b1;
            end
            else if (busy)
            begin
                assert (request_held())
                else fail_run($sformatf("[FAIL] %0t ns: request changed before ack", $time));
                wait_left--;
                if (wait_left <= 0)
                    finish_request();
            end
            else if (mem_rd_en || mem_wr_en)
            begin
                if (!first_done)
                begin
                    assert (cycle_count == 2 && mem_rd_en && mem_addr == 64'd0
                            && mem_byte_en == 8'h0f)
                    else fail_run($sformatf("[FAIL] %0t ns: bad first fetch %h", $time,
                                            mem_addr));
                    first_done = 1'b1;
                end
                busy      = 1'b1;
                req_addr  = mem_addr;
                req_be    = mem_byte_en;
                req_wr    = mem_wr_en;
                req_wdata = mem_wdata;
                random_delay(wait_left);
                if (wait_left == 0)
                    finish_request();
            end
        end
    end

endmodule

// ==== tb/program_input.txt ====
// word count, program words (one per entry), store count,
// then per store: address, byte enables, write data
29
ffb00093 10000113 00113023 00409193 4021d213 401202b3 00513423 80000337
00135393 0063c433 00813823 0020a4b3 0020b533 00001597 00b48633 00c12c23
021100a3 02511323 02110683 02615703 00416783 00e68833 03013423 02f13823
0020c463 02013c23 0020f463 02013c23 00208463 00109463 00116463 02013c23
00115463 02013c23 008008ef 02013c23 05113023 01088967 02013c23 05213423
00000000
a
100 ff fffffffffffffffb
108 ff fffffffffffffff1
110 ff 8000000040000000
118 0f 0000000000001035
121 02 fffffffffffffb00
126 c0 fff1000000000000
128 ff 000000000000ffec
130 ff 00000000ffffffff
140 ff 000000000000008c
148 ff 0000000000000098

// ==== vlog.f ====
rtl/rv_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/datapath.sv
rtl/control_unit.sv
rtl/rv64i_core.sv
tb/tb_clock_gen.sv
tb/rv64i_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = rv64i_tb
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
